//--- common/amtPkg.sv
// Architectural map table package
// Sizes of the register files and commit window, plus the packet,
// commit slot, release slot and storage write port types
`default_nettype none

package amtPkg;

  // Logical register file
  localparam int NumLogical   = 32;
  localparam int LogicalBits  = 5;

  // Physical register file
  localparam int NumPhysical  = 64;
  localparam int PhysicalBits = 6;

  // Retire slots per cycle, also the RAM port count
  localparam int CommitWidth  = 4;

  // Cycles needed to stream the whole table to the rename map
  localparam int RecoverSteps = NumLogical / CommitWidth;

  // Logical to physical pairing, shared by commit and recovery
  typedef struct packed {
    logic [LogicalBits-1:0]  logical;
    logic [PhysicalBits-1:0] physical;
  } amtPacket_t;

  // One retiring instruction from the active list
  typedef struct packed {
    logic       valid;
    amtPacket_t pkt;
  } commitSlot_t;

  // Register handed back to the free list
  typedef struct packed {
    logic                    valid;
    logic [PhysicalBits-1:0] physical;
  } releaseSlot_t;

  // One storage write port
  typedef struct packed {
    logic                    we;
    logic [LogicalBits-1:0]  addr;
    logic [PhysicalBits-1:0] data;
  } ramWrite_t;

endpackage

`default_nettype wire

//--- archMapTable/commitFilter.sv
// Commit filter
// Finds slots in the commit window whose logical destination is
// named again by a younger valid slot; only the youngest of such a
// group drives a write port of the table
`timescale 1ns/1ps
`default_nettype none

module commitFilter
  import amtPkg::*;
(
  input  commitSlot_t [CommitWidth-1:0] commit_i,
  output ramWrite_t   [CommitWidth-1:0] ramWr_o,
  output logic        [CommitWidth-1:0] overridden_o
);

  // Per slot collision flag, built before the write ports
  logic [CommitWidth-1:0] hit;

  // Compare each slot with every younger slot
  always_comb begin
    hit = '0;
    for (int i = 0; i < CommitWidth; i++) begin
      for (int j = i + 1; j < CommitWidth; j++) begin
        // Invalid younger slots carry no destination
        if (commit_i[j].valid &&
            (commit_i[j].pkt.logical == commit_i[i].pkt.logical)) begin
          hit[i] = 1'b1;
        end
      end
    end
  end

  // Youngest slot can never be overridden
  // since no slot follows it in the window

  // Form write ports
  always_comb begin
    for (int i = 0; i < CommitWidth; i++) begin
      // Only a surviving valid slot writes
      ramWr_o[i].we   = commit_i[i].valid & ~hit[i];
      ramWr_o[i].addr = commit_i[i].pkt.logical;
      ramWr_o[i].data = commit_i[i].pkt.physical;
    end
  end

  // Release path needs to know which slots lost
  assign overridden_o = hit;

endmodule

`default_nettype wire

//--- archMapTable/mapTableRam.sv
// Map table storage
// One physical index per logical register, four asynchronous read
// ports and four write ports that apply at the clock edge; reset
// loads the identity mapping
`timescale 1ns/1ps
`default_nettype none

module mapTableRam
  import amtPkg::*;
(
  input  wire                                      clk,
  input  wire                                      reset,
  // Filtered commit writes
  input  ramWrite_t [CommitWidth-1:0]              ramWr_i,
  // Read addresses from the return path
  input  wire       [CommitWidth-1:0][LogicalBits-1:0]  rdAddr_i,
  // Current mappings
  output logic      [CommitWidth-1:0][PhysicalBits-1:0] rdData_o
);

  // Table contents, indexed by logical register
  logic [PhysicalBits-1:0] mapMem [NumLogical];

  // Write side
  always_ff @(posedge clk) begin
    if (reset) begin
      // Logical register i starts in physical register i
      for (int i = 0; i < NumLogical; i++) begin
        mapMem[i] <= PhysicalBits'(i);
      end
    end else begin
      // At most one enabled port per address,
      // so port order has no effect
      for (int p = 0; p < CommitWidth; p++) begin
        if (ramWr_i[p].we) begin
          mapMem[ramWr_i[p].addr] <= ramWr_i[p].data;
        end
      end
    end
  end

  // Reads see the table before this cycle's writes
  always_comb begin
    for (int p = 0; p < CommitWidth; p++) begin
      rdData_o[p] = mapMem[rdAddr_i[p]];
    end
  end

endmodule

`default_nettype wire

//--- archMapTable/mapReturn.sv
// Release and recovery return path
// Picks the table read addresses, turns read data into released
// registers for the free list, and walks the table four entries per
// cycle while recovery is in progress
`timescale 1ns/1ps
`default_nettype none

module mapReturn
  import amtPkg::*;
(
  input  wire                                           clk,
  input  wire                                           reset,
  // Retiring slots
  input  commitSlot_t  [CommitWidth-1:0]                commit_i,
  // Collision result from the commit filter
  input  wire          [CommitWidth-1:0]                overridden_i,
  // Level flag, held for one whole walk
  input  wire                                           recoverFlag_i,
  // Table read data
  input  wire          [CommitWidth-1:0][PhysicalBits-1:0] rdData_i,
  // Table read addresses
  output logic         [CommitWidth-1:0][LogicalBits-1:0]  rdAddr_o,
  // To the free list
  output releaseSlot_t [CommitWidth-1:0]                release_o,
  // To the rename map table
  output amtPacket_t   [CommitWidth-1:0]                recoverPacket_o
);

  // Last group of the walk starts here
  localparam logic [LogicalBits-1:0] LastGroup = LogicalBits'(NumLogical - CommitWidth);

  // First table entry shown this cycle during recovery
  logic [LogicalBits-1:0] recoverIdx;

  // Walk pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      recoverIdx <= '0;
    end else if (recoverFlag_i) begin
      // Wrap so the next walk begins at entry 0
      if (recoverIdx == LastGroup) begin
        recoverIdx <= '0;
      end else begin
        recoverIdx <= recoverIdx + LogicalBits'(CommitWidth);
      end
    end
  end

  // Read address select
  always_comb begin
    for (int i = 0; i < CommitWidth; i++) begin
      if (recoverFlag_i) begin
        // Consecutive entries of the current group
        rdAddr_o[i] = recoverIdx + LogicalBits'(i);
      end else begin
        // Mapping about to be replaced
        rdAddr_o[i] = commit_i[i].pkt.logical;
      end
    end
  end

  // Released registers
  always_comb begin
    for (int i = 0; i < CommitWidth; i++) begin
      release_o[i].valid = commit_i[i].valid;
      // Overridden slot never reaches the table,
      // so its own new register goes back
      if (overridden_i[i]) begin
        release_o[i].physical = commit_i[i].pkt.physical;
      end else begin
        release_o[i].physical = rdData_i[i];
      end
    end
  end

  // Recovery packets pair each address with its data
  always_comb begin
    for (int i = 0; i < CommitWidth; i++) begin
      recoverPacket_o[i].logical  = rdAddr_o[i];
      recoverPacket_o[i].physical = rdData_i[i];
    end
  end

endmodule

`default_nettype wire

//--- archMapTable/archMapTable.sv
// Architectural map table
// Tracks the committed physical register of every logical register,
// releases replaced mappings to the free list and streams the table
// to the rename map during recovery
`timescale 1ns/1ps
`default_nettype none

module archMapTable
  import amtPkg::*;
(
  input  wire                                      clk,
  input  wire                                      reset,
  // Retiring slots, slot 0 oldest
  input  commitSlot_t  [CommitWidth-1:0]           commit_i,
  // Level flag from the active list
  input  wire                                      recoverFlag_i,
  // To the free list
  output releaseSlot_t [CommitWidth-1:0]           release_o,
  // To the rename map table
  output amtPacket_t   [CommitWidth-1:0]           recoverPacket_o
);

  // Write ports after collision filtering
  ramWrite_t [CommitWidth-1:0]                   ramWr;
  // Slot loses to a younger slot with the same destination
  logic      [CommitWidth-1:0]                   overridden;
  // Storage read ports
  logic      [CommitWidth-1:0][LogicalBits-1:0]  rdAddr;
  logic      [CommitWidth-1:0][PhysicalBits-1:0] rdData;

  commitFilter i_commitFilter (
    .commit_i     (commit_i),
    .ramWr_o      (ramWr),
    .overridden_o (overridden)
  );

  mapTableRam i_mapTableRam (
    .clk      (clk),
    .reset    (reset),
    .ramWr_i  (ramWr),
    .rdAddr_i (rdAddr),
    .rdData_o (rdData)
  );

  mapReturn i_mapReturn (
    .clk             (clk),
    .reset           (reset),
    .commit_i        (commit_i),
    .overridden_i    (overridden),
    .recoverFlag_i   (recoverFlag_i),
    .rdData_i        (rdData),
    .rdAddr_o        (rdAddr),
    .release_o       (release_o),
    .recoverPacket_o (recoverPacket_o)
  );

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
// Testbench clock and reset
// 20 ns clock, reset held high for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic reset
);

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release reset on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/archMapTable_chk.sv
// Map table checker
// Keeps a shadow of the committed mapping and a walk counter, and
// compares releases and recovery packets against them
`timescale 1ns/1ps
`default_nettype none

module archMapTable_chk
  import amtPkg::*;
(
  input wire                                clk,
  input wire                                reset,
  input commitSlot_t  [CommitWidth-1:0]     commit_i,
  input wire                                recoverFlag_i,
  input releaseSlot_t [CommitWidth-1:0]     release_o,
  input amtPacket_t   [CommitWidth-1:0]     recoverPacket_o
);

  // Failed assertion count, read by the testbench top
  int failCount = 0;

  // Committed mapping as seen from outside
  logic [PhysicalBits-1:0] shadow [NumLogical];
  // Group number of the current recovery cycle
  int unsigned walkStep;

  logic [CommitWidth-1:0][PhysicalBits-1:0] expRelease;
  amtPacket_t [CommitWidth-1:0]             expPacket;

  // Oldest to youngest, so the youngest valid slot ends up in the shadow
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumLogical; i++) begin
        shadow[i] <= PhysicalBits'(i);
      end
    end else begin
      for (int s = 0; s < CommitWidth; s++) begin
        if (commit_i[s].valid) begin
          shadow[commit_i[s].pkt.logical] <= commit_i[s].pkt.physical;
        end
      end
    end
  end

  // One group per flagged cycle, wrapping after the full table
  always_ff @(posedge clk) begin
    if (reset) begin
      walkStep <= 0;
    end else if (recoverFlag_i) begin
      walkStep <= (walkStep + 1) % RecoverSteps;
    end
  end

  // Expected outputs
  always_comb begin
    for (int s = 0; s < CommitWidth; s++) begin
      // Replaced mapping, unless a younger valid slot takes the register
      expRelease[s] = shadow[commit_i[s].pkt.logical];
      for (int y = s + 1; y < CommitWidth; y++) begin
        if (commit_i[y].valid && (commit_i[y].pkt.logical == commit_i[s].pkt.logical)) begin
          expRelease[s] = commit_i[s].pkt.physical;
        end
      end
      expPacket[s].logical  = LogicalBits'(walkStep * CommitWidth + s);
      expPacket[s].physical = shadow[expPacket[s].logical];
    end
  end

  for (genvar s = 0; s < CommitWidth; s++) begin : gSlot
    releaseValid: assert property (@(posedge clk) disable iff (reset)
        release_o[s].valid == commit_i[s].valid)
      else begin
        failCount++;
        $error("Error at %0t: release slot %0d valid %0b, expected %0b", $time, s,
               $sampled(release_o[s].valid), $sampled(commit_i[s].valid));
      end

    releaseReg: assert property (@(posedge clk) disable iff (reset)
        commit_i[s].valid |-> release_o[s].physical == expRelease[s])
      else begin
        failCount++;
        $error("Error at %0t: release slot %0d register %0d, expected %0d", $time, s,
               $sampled(release_o[s].physical), $sampled(expRelease[s]));
      end

    // Logical index and mapping of each walk entry
    recoverPkt: assert property (@(posedge clk) disable iff (reset)
        recoverFlag_i |-> recoverPacket_o[s] == expPacket[s])
      else begin
        failCount++;
        $error("Error at %0t: recovery slot %0d packet %0h, expected %0h", $time, s,
               $sampled(recoverPacket_o[s]), $sampled(expPacket[s]));
      end
  end

endmodule

`default_nettype wire

//--- testbench/archMapTableTb.sv
// Map table testbench
// Drives commit windows and recovery walks; the bound checker
// compares every cycle, this top reports per test and at the end
`timescale 1ns/1ps
`default_nettype none

module archMapTableTb
  import amtPkg::*;
();

  localparam int ResetTimeout = 50;

  logic                                clk;
  logic                                reset;
  commitSlot_t  [CommitWidth-1:0]      commit;
  logic                                recoverFlag;
  releaseSlot_t [CommitWidth-1:0]      releaseSlots;
  amtPacket_t   [CommitWidth-1:0]      recoverPacket;

  int  testsRun;
  int  testsFailed;
  int  failsBefore;
  logic resetOk;

  tbClock i_tbClock (
    .clk   (clk),
    .reset (reset)
  );

  archMapTable i_archMapTable (
    .clk             (clk),
    .reset           (reset),
    .commit_i        (commit),
    .recoverFlag_i   (recoverFlag),
    .release_o       (releaseSlots),
    .recoverPacket_o (recoverPacket)
  );

  bind archMapTable archMapTable_chk i_chk (
    .clk             (clk),
    .reset           (reset),
    .commit_i        (commit_i),
    .recoverFlag_i   (recoverFlag_i),
    .release_o       (release_o),
    .recoverPacket_o (recoverPacket_o)
  );

  function automatic commitSlot_t makeSlot(input logic valid, input int logical, input int phys);
    commitSlot_t s;
    s.valid        = valid;
    s.pkt.logical  = LogicalBits'(logical);
    s.pkt.physical = PhysicalBits'(phys);
    return s;
  endfunction

  function automatic int randomPhys();
    return int'($urandom % NumPhysical);
  endfunction

  // Inputs change on the falling edge only
  task automatic driveCycle(input commitSlot_t [CommitWidth-1:0] slots, input logic flag);
    @(negedge clk);
    commit      = slots;
    recoverFlag = flag;
  endtask

  task automatic idleCycles(input int n);
    for (int k = 0; k < n; k++) begin
      driveCycle('0, 1'b0);
    end
  endtask

  // Flag held for exactly one walk
  task automatic recoveryWalk();
    for (int k = 0; k < RecoverSteps; k++) begin
      driveCycle('0, 1'b1);
    end
    idleCycles(1);
  endtask

  task automatic waitResetDone(output logic ok);
    int cycles;
    cycles = 0;
    while ((reset !== 1'b0) && (cycles < ResetTimeout)) begin
      @(posedge clk);
      cycles++;
    end
    ok = (reset === 1'b0);
    if (!ok) begin
      $display("Timeout: reset still high after %0d cycles", ResetTimeout);
    end
  endtask

  task automatic startTest();
    failsBefore = i_archMapTable.i_chk.failCount;
  endtask

  task automatic finishTest(input string name);
    int fails;
    idleCycles(1);
    fails = i_archMapTable.i_chk.failCount - failsBefore;
    testsRun++;
    if (fails != 0) begin
      testsFailed++;
    end
    $display("Test %0d %s: %s, %0d assertion failures", testsRun, name,
             (fails == 0) ? "passed" : "failed", fails);
  endtask

  task automatic runTests();
    commitSlot_t [CommitWidth-1:0] w;
    // Identity mapping after reset
    startTest();
    idleCycles(3);
    w = '0;
    w[0] = makeSlot(1'b1, 5, 40);
    driveCycle(w, 1'b0);
    finishTest("reset mapping");
    // Distinct destinations, then the same ones again
    startTest();
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < CommitWidth; s++) begin
        w[s] = makeSlot(1'b1, 8 + s, randomPhys());
      end
      driveCycle(w, 1'b0);
    end
    finishTest("distinct destinations");
    // Whole window on one register, then two pairs
    startTest();
    for (int s = 0; s < CommitWidth; s++) begin
      w[s] = makeSlot(1'b1, 12, randomPhys());
    end
    driveCycle(w, 1'b0);
    for (int s = 0; s < CommitWidth; s++) begin
      w[s] = makeSlot(1'b1, 13 + (s % 2), randomPhys());
    end
    driveCycle(w, 1'b0);
    finishTest("colliding destinations");
    // Invalid younger slots must not override
    startTest();
    w[0] = makeSlot(1'b1, 15, randomPhys());
    w[1] = makeSlot(1'b0, 15, randomPhys());
    w[2] = makeSlot(1'b1, 16, randomPhys());
    w[3] = makeSlot(1'b0, 16, randomPhys());
    driveCycle(w, 1'b0);
    w[0] = makeSlot(1'b0, 17, randomPhys());
    w[1] = makeSlot(1'b1, 17, randomPhys());
    w[2] = makeSlot(1'b0, 15, randomPhys());
    w[3] = makeSlot(1'b1, 16, randomPhys());
    driveCycle(w, 1'b0);
    finishTest("invalid slots");
    startTest();
    recoveryWalk();
    finishTest("first recovery walk");
    // Random traffic, then a walk from entry 0 again
    startTest();
    for (int c = 0; c < 40; c++) begin
      for (int s = 0; s < CommitWidth; s++) begin
        w[s] = makeSlot(1'($urandom), int'($urandom % NumLogical), randomPhys());
      end
      driveCycle(w, 1'b0);
    end
    idleCycles(1);
    recoveryWalk();
    finishTest("second recovery walk");
  endtask

  initial begin
    commit      = '0;
    recoverFlag = 1'b0;
    testsRun    = 0;
    testsFailed = 0;
    failsBefore = 0;
    void'($urandom(32'hb8f18bf9));
    waitResetDone(resetOk);
    if (resetOk) begin
      runTests();
    end
    $display("Tests run %0d, tests failed %0d, assertion failures %0d", testsRun,
             testsFailed, i_archMapTable.i_chk.failCount);
    if (resetOk && i_archMapTable.i_chk.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/amtPkg.sv
archMapTable/commitFilter.sv
archMapTable/mapTableRam.sv
archMapTable/mapReturn.sv
archMapTable/archMapTable.sv
testbench/tbClock.sv
testbench/archMapTable_chk.sv
testbench/archMapTableTb.sv
